// File: files.f
hw/rv_fetch_pkg.sv
hw/rv_btb.sv
hw/rv_ras.sv
hw/rv_pc_sel.sv
hw/rv_pc_gen.sv
hw/rv_fetch_top.sv
verif/rv_fetch_assert.sv
verif/rv_fetch_checker.sv
verif/rv_fetch_tb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator and run, success only if the pass message is printed
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f files.f --top-module rv_fetch_tb -o rv_fetch_sim \
    && ./obj_dir/rv_fetch_sim | tee /dev/stderr | grep -q "Simulation PASSED" \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

// File: verif/rv_fetch_tb.sv
`timescale 1ns/10ps

module rv_fetch_tb;

    localparam logic [31:0] RESET_VECTOR = 32'h0000_1000;
    localparam int          RESET_CYCLES = 8;

    // A table row holds the controls for one fetch and the address that follows it
    typedef struct packed {
        logic [7:0]                test;
        rv_fetch_pkg::redirect_t   mem;
        rv_fetch_pkg::ex_sel_t     ex;
        rv_fetch_pkg::id_info_t    id;
        rv_fetch_pkg::btb_update_t upd;
        rv_fetch_pkg::ras_op_t     ras;
        logic [31:0]               exp_adr;
        logic                      chk_flags;
        logic                      exp_btb;
        logic                      exp_ras;
    } step_t;

    logic                      clk;
    logic                      reset;
    rv_fetch_pkg::redirect_t   mem_redir;
    rv_fetch_pkg::ex_sel_t     ex_sel;
    rv_fetch_pkg::id_info_t    id_info;
    rv_fetch_pkg::btb_update_t btb_upd;
    rv_fetch_pkg::ras_op_t     ras_op;
    logic                      wb_cyc;
    logic                      wb_stb;
    logic                      wb_we;
    logic [3:0]                wb_sel;
    logic [31:0]               wb_adr;
    logic                      wb_ack;
    logic [31:0]               wb_dat_i;
    logic [31:0]               instr;
    logic                      instr_valid;
    logic                      btb_pred_taken;
    logic                      ras_pred_taken;
    logic                      check_en;
    logic [31:0]               exp_adr;
    logic                      chk_flags;
    logic                      exp_btb;
    logic                      exp_ras;
    logic [7:0]                test_num;
    int                        err_count;
    int                        check_count;
    int                        seed = 6;
    int                        waits;
    int                        cycles;
    int                        timeout_limit;
    step_t                     steps[$];
    step_t                     cur;

    rv_fetch_top #(
        .RESET_VECTOR (RESET_VECTOR)
    ) i_dut (
        .clk            (clk),
        .reset          (reset),
        .mem_redir      (mem_redir),
        .ex_sel         (ex_sel),
        .id_info        (id_info),
        .btb_upd        (btb_upd),
        .ras_op         (ras_op),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_sel         (wb_sel),
        .wb_adr         (wb_adr),
        .wb_ack         (wb_ack),
        .wb_dat_i       (wb_dat_i),
        .instr          (instr),
        .instr_valid    (instr_valid),
        .btb_pred_taken (btb_pred_taken),
        .ras_pred_taken (ras_pred_taken)
    );

    rv_fetch_checker i_chk (
        .clk            (clk),
        .reset          (reset),
        .check_en       (check_en),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_sel         (wb_sel),
        .wb_ack         (wb_ack),
        .wb_adr         (wb_adr),
        .instr          (instr),
        .instr_valid    (instr_valid),
        .btb_pred_taken (btb_pred_taken),
        .ras_pred_taken (ras_pred_taken),
        .exp_adr        (exp_adr),
        .chk_flags      (chk_flags),
        .exp_btb        (exp_btb),
        .exp_ras        (exp_ras),
        .test_num       (test_num),
        .err_count      (err_count),
        .check_count    (check_count)
    );

    bind rv_fetch_top rv_fetch_assert i_fetch_assert (
        .clk    (clk),
        .reset  (reset),
        .wb_cyc (wb_cyc),
        .wb_stb (wb_stb),
        .wb_ack (wb_ack),
        .wb_adr (wb_adr),
        .pc     (pc)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Each row builder fills one field of the row under construction
    task automatic predict_id(input rv_fetch_pkg::pc_sel_t sel, input logic [31:0] tgt,
                              input logic jalr);
        cur.id = '{sel: sel, pred_tgt: tgt, is_jalr: jalr};
    endtask

    task automatic redirect_ex(input logic [31:0] tgt);
        cur.ex = '{sel: rv_fetch_pkg::PC_SEL_REDIRECT, tgt: tgt};
    endtask

    task automatic redirect_mem(input logic [31:0] tgt);
        cur.mem = '{valid: 1'b1, tgt: tgt};
    endtask

    task automatic train_btb(input logic taken, input logic ret, input logic [31:0] pc,
                             input logic [31:0] tgt);
        cur.upd = '{valid: 1'b1, taken: taken, is_return: ret, pc: pc, tgt: tgt};
    endtask

    task automatic ras_cmd(input logic push, input logic pop, input logic [31:0] addr);
        cur.ras = '{push: push, pop: pop, push_addr: addr};
    endtask

    task automatic expect_flags(input logic btb, input logic ras);
        cur.chk_flags = 1'b1;
        cur.exp_btb   = btb;
        cur.exp_ras   = ras;
    endtask

    task automatic add_step(input int test, input logic [31:0] exp);
        cur.test    = 8'(test);
        cur.exp_adr = exp;
        steps.push_back(cur);
        cur = '0;
    endtask

    task automatic report_test(input logic [7:0] test, input int errs_before);
        if (err_count == errs_before) begin
            $display("Test %0d passed", test);
        end else begin
            $display("Test %0d failed with %0d errors", test, err_count - errs_before);
        end
    endtask

    // Expected addresses follow the next-PC rule for the fetch that each row controls
    task automatic build_table();
        cur = '0;
        // Sequential fetch from the reset vector
        add_step(1, 32'h1004);
        add_step(1, 32'h1008);
        add_step(1, 32'h100c);
        add_step(1, 32'h1010);
        // The fetch at 0x1010 trains a taken entry for 0x1018
        // and a later one trains 0x1108 as not taken
        train_btb(1'b1, 1'b0, 32'h1018, 32'h1100);
        add_step(2, 32'h1014);
        add_step(2, 32'h1018);
        expect_flags(1'b1, 1'b0);
        add_step(2, 32'h1100);
        train_btb(1'b0, 1'b0, 32'h1108, 32'h1200);
        add_step(2, 32'h1104);
        add_step(2, 32'h1108);
        expect_flags(1'b0, 1'b0);
        add_step(2, 32'h110c);
        // Early RAS case at 0x1118 before the stack is popped
        // and the return entry falls back to the static rule
        ras_cmd(1'b1, 1'b0, 32'h1500);
        train_btb(1'b0, 1'b1, 32'h1118, 32'h1800);
        add_step(3, 32'h1110);
        add_step(3, 32'h1114);
        add_step(3, 32'h1118);
        expect_flags(1'b1, 1'b0);
        add_step(3, 32'h1500);
        ras_cmd(1'b0, 1'b1, 32'h0);
        add_step(3, 32'h1504);
        predict_id(rv_fetch_pkg::PC_SEL_PREDICTED, 32'h1118, 1'b0);
        add_step(3, 32'h1118);
        add_step(3, 32'h111c);
        // In the late RAS case the JALR in ID uses the state buffered at 0x1120
        ras_cmd(1'b1, 1'b0, 32'h1600);
        add_step(4, 32'h1120);
        add_step(4, 32'h1124);
        predict_id(rv_fetch_pkg::PC_SEL_SEQ, 32'h0, 1'b1);
        expect_flags(1'b0, 1'b1);
        add_step(4, 32'h1600);
        ras_cmd(1'b0, 1'b1, 32'h0);
        add_step(4, 32'h1604);
        // ID prediction beats a taken BTB entry and then an early RAS return
        train_btb(1'b1, 1'b0, 32'h1608, 32'h1700);
        add_step(5, 32'h1608);
        predict_id(rv_fetch_pkg::PC_SEL_PREDICTED, 32'h1a00, 1'b0);
        expect_flags(1'b0, 1'b0);
        add_step(5, 32'h1a00);
        ras_cmd(1'b1, 1'b0, 32'h1c00);
        train_btb(1'b0, 1'b1, 32'h1a08, 32'h1e00);
        add_step(5, 32'h1a04);
        add_step(5, 32'h1a08);
        predict_id(rv_fetch_pkg::PC_SEL_PREDICTED, 32'h1b00, 1'b0);
        train_btb(1'b1, 1'b0, 32'h1b00, 32'h1f00);
        add_step(5, 32'h1b00);
        // EX beats ID with a taken BTB entry and then the RAS and MEM beats EX
        redirect_ex(32'h2000);
        predict_id(rv_fetch_pkg::PC_SEL_PREDICTED, 32'h1d00, 1'b0);
        add_step(6, 32'h2000);
        redirect_mem(32'h1a08);
        add_step(6, 32'h1a08);
        redirect_ex(32'h2100);
        predict_id(rv_fetch_pkg::PC_SEL_SEQ, 32'h0, 1'b1);
        add_step(6, 32'h2100);
        redirect_mem(32'h3000);
        redirect_ex(32'h2200);
        add_step(6, 32'h3000);
        add_step(6, 32'h3004);
    endtask

    // Memory slave with 0 to 2 wait states that returns the address as data
    initial begin
        wb_ack   = 1'b0;
        wb_dat_i = '0;
        waits    = $unsigned($random(seed)) % 3;
        forever begin
            @(posedge clk);
            #1;
            if (wb_ack) begin
                wb_ack = 1'b0;
                waits  = $unsigned($random(seed)) % 3;
            end
            if (!reset && wb_cyc && wb_stb) begin
                if (waits == 0) begin
                    wb_ack   = 1'b1;
                    wb_dat_i = wb_adr;
                end else begin
                    waits--;
                end
            end
        end
    end

    // Run limit from the table length since every fetch finishes within three cycles
    initial begin
        cycles = 0;
        while (timeout_limit == 0 || cycles < timeout_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the fetch sequence did not finish in %0d cycles", cycles);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        logic       got_ack;
        logic       report_due;
        logic [7:0] prev_test;
        int         errs_before;
        reset     = 1'b1;
        mem_redir = '0;
        ex_sel    = '0;
        id_info   = '0;
        btb_upd   = '0;
        ras_op    = '0;
        check_en  = 1'b1;
        exp_adr   = RESET_VECTOR;
        chk_flags = 1'b0;
        exp_btb   = 1'b0;
        exp_ras   = 1'b0;
        test_num  = 8'd1;
        timeout_limit = 0;
        build_table();
        timeout_limit = steps.size() * 4 + RESET_CYCLES + 50;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset       = 1'b0;
        prev_test   = steps[0].test;
        errs_before = 0;
        report_due  = 1'b0;
        for (int i = 0; i < steps.size(); i++) begin
            test_num  = steps[i].test;
            mem_redir = steps[i].mem;
            ex_sel    = steps[i].ex;
            id_info   = steps[i].id;
            btb_upd   = steps[i].upd;
            ras_op    = steps[i].ras;
            chk_flags = steps[i].chk_flags;
            exp_btb   = steps[i].exp_btb;
            exp_ras   = steps[i].exp_ras;
            if (steps[i].test != prev_test) begin
                report_due = 1'b1;
            end
            got_ack = 1'b0;
            while (!got_ack) begin
                @(posedge clk);
                got_ack = wb_ack;
                #1;
                // Training and stack commands are single cycle pulses
                btb_upd = '0;
                ras_op  = '0;
                // The address check of the previous test has now been made
                if (report_due) begin
                    report_test(prev_test, errs_before);
                    errs_before = err_count;
                    prev_test   = steps[i].test;
                    report_due  = 1'b0;
                end
            end
            chk_flags = 1'b0;
            exp_adr   = steps[i].exp_adr;
        end
        // Let the last expected address be compared before checking stops
        @(posedge clk);
        #1;
        check_en = 1'b0;
        report_test(prev_test, errs_before);
        $display("Checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: verif/rv_fetch_checker.sv
`timescale 1ns/10ps

module rv_fetch_checker (
    input  logic        clk,
    input  logic        reset,
    input  logic        check_en,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [3:0]  wb_sel,
    input  logic        wb_ack,
    input  logic [31:0] wb_adr,
    input  logic [31:0] instr,
    input  logic        instr_valid,
    input  logic        btb_pred_taken,
    input  logic        ras_pred_taken,
    // Reference values from the stimulus table
    input  logic [31:0] exp_adr,
    input  logic        chk_flags,
    input  logic        exp_btb,
    input  logic        exp_ras,
    input  logic [7:0]  test_num,
    output int          err_count,
    output int          check_count
);

    // Set while the next bus cycle is the first one of a new request
    logic        new_req;
    // Expected address of the request in progress, the slave returns it as data
    logic [31:0] req_adr;

    initial begin
        err_count   = 0;
        check_count = 0;
        new_req     = 1'b1;
        req_adr     = '0;
    end

    // Values read here are those of the cycle that just ended
    always @(posedge clk) begin
        if (reset) begin
            new_req = 1'b1;
        end else if (wb_cyc && wb_stb) begin
            if (new_req) begin
                req_adr = exp_adr;
            end
            if (new_req && check_en) begin
                check_count++;
                if (wb_adr !== exp_adr) begin
                    err_count++;
                    $display("Error: wb_adr expected %h got %h in test %0d",
                             exp_adr, wb_adr, test_num);
                end
                // The fetch port only reads and always takes the whole word
                if (wb_we !== 1'b0) begin
                    err_count++;
                    $display("Error: wb_we expected 0 got %h in test %0d",
                             wb_we, test_num);
                end
                if (wb_sel !== 4'hf) begin
                    err_count++;
                    $display("Error: wb_sel expected f got %h in test %0d",
                             wb_sel, test_num);
                end
            end
            // The fetched word leaves in the ack cycle and in no other
            if (check_en) begin
                if (instr_valid !== wb_ack) begin
                    err_count++;
                    $display("Error: instr_valid expected %h got %h in test %0d",
                             wb_ack, instr_valid, test_num);
                end
                if (wb_ack) begin
                    check_count++;
                    if (instr !== req_adr) begin
                        err_count++;
                        $display("Error: instr expected %h got %h in test %0d",
                                 req_adr, instr, test_num);
                    end
                end
            end
            // Prediction kind is only meaningful on the ack edge
            if (wb_ack && chk_flags) begin
                check_count++;
                if (btb_pred_taken !== exp_btb) begin
                    err_count++;
                    $display("Error: btb_pred_taken expected %h got %h in test %0d",
                             exp_btb, btb_pred_taken, test_num);
                end
                if (ras_pred_taken !== exp_ras) begin
                    err_count++;
                    $display("Error: ras_pred_taken expected %h got %h in test %0d",
                             exp_ras, ras_pred_taken, test_num);
                end
            end
            new_req = wb_ack;
        end
    end

endmodule

// File: verif/rv_fetch_assert.sv
`timescale 1ns/10ps

module rv_fetch_assert (
    input logic        clk,
    input logic        reset,
    input logic        wb_cyc,
    input logic        wb_stb,
    input logic        wb_ack,
    input logic [31:0] wb_adr,
    input logic [31:0] pc
);

    // The bus cycle opens in the first cycle after reset with the strobe inside it
    a_req_open: assert property (@(posedge clk)
        $fell(reset) |=> (wb_cyc && wb_stb))
        else $error("wb_cyc and wb_stb did not rise in the first cycle after reset");

    // A pending request must not change under the slave
    a_req_hold: assert property (@(posedge clk) disable iff (reset)
        (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr)))
        else $error("wb_adr or wb_stb changed during a wait state");

    // The PC register holds only word addresses since there are no compressed instructions
    // The bus address is then the PC itself
    a_word_aligned: assert property (@(posedge clk) disable iff (reset)
        (pc[1:0] == 2'b00) && (wb_adr == pc))
        else $error("wb_adr is not the word aligned pc");

endmodule

// File: hw/rv_fetch_top.sv
`timescale 1ns/10ps

module rv_fetch_top #(
    parameter int              XLEN         = rv_fetch_pkg::XLEN,
    parameter logic [XLEN-1:0] RESET_VECTOR = 'h0000_1000,
    parameter int              BTB_ENTRIES  = 16,
    parameter int              RAS_DEPTH    = 4
) (
    input  logic                      clk,
    input  logic                      reset,
    // Control from the later pipeline stages
    input  rv_fetch_pkg::redirect_t   mem_redir,
    input  rv_fetch_pkg::ex_sel_t     ex_sel,
    input  rv_fetch_pkg::id_info_t    id_info,
    input  rv_fetch_pkg::btb_update_t btb_upd,
    input  rv_fetch_pkg::ras_op_t     ras_op,
    // Wishbone fetch port
    output logic                      wb_cyc,
    output logic                      wb_stb,
    output logic                      wb_we,
    output logic [3:0]                wb_sel,
    output logic [XLEN-1:0]           wb_adr,
    input  logic                      wb_ack,
    input  logic [31:0]               wb_dat_i,
    // Fetched instruction and prediction kind for the hazard unit
    output logic [31:0]               instr,
    output logic                      instr_valid,
    output logic                      btb_pred_taken,
    output logic                      ras_pred_taken
);

    logic [XLEN-1:0]           pc;
    logic [XLEN-1:0]           next_tgt;
    logic                      ras_valid;
    logic [XLEN-1:0]           ras_tgt;
    rv_fetch_pkg::btb_lookup_t btb_lookup;
    rv_fetch_pkg::if_id_pred_t if_id;
    rv_fetch_pkg::pc_sel_t     pc_sel;

    // PC register and bus master
    rv_pc_gen #(
        .XLEN         (XLEN),
        .RESET_VECTOR (RESET_VECTOR)
    ) i_pc_gen (
        .clk         (clk),
        .reset       (reset),
        .pc_sel      (pc_sel),
        .next_tgt    (next_tgt),
        .ras_valid   (ras_valid),
        .ras_tgt     (ras_tgt),
        .btb         (btb_lookup),
        .pc          (pc),
        .if_id       (if_id),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_sel      (wb_sel),
        .wb_adr      (wb_adr),
        .wb_ack      (wb_ack),
        .wb_dat_i    (wb_dat_i),
        .instr       (instr),
        .instr_valid (instr_valid)
    );

    // BTB looks up the address currently on the bus
    rv_btb #(
        .XLEN        (XLEN),
        .BTB_ENTRIES (BTB_ENTRIES)
    ) i_btb (
        .clk    (clk),
        .reset  (reset),
        .pc     (pc),
        .upd    (btb_upd),
        .lookup (btb_lookup)
    );

    rv_ras #(
        .XLEN      (XLEN),
        .RAS_DEPTH (RAS_DEPTH)
    ) i_ras (
        .clk       (clk),
        .reset     (reset),
        .op        (ras_op),
        .ras_valid (ras_valid),
        .ras_tgt   (ras_tgt)
    );

    // Next PC arbitration, purely combinational
    rv_pc_sel #(
        .XLEN (XLEN)
    ) i_pc_sel (
        .mem_redir      (mem_redir),
        .ex_sel         (ex_sel),
        .id_info        (id_info),
        .ras_valid      (ras_valid),
        .ras_tgt        (ras_tgt),
        .btb            (btb_lookup),
        .if_id          (if_id),
        .pc_sel         (pc_sel),
        .next_tgt       (next_tgt),
        .btb_pred_taken (btb_pred_taken),
        .ras_pred_taken (ras_pred_taken)
    );

endmodule

// File: hw/rv_pc_gen.sv
`timescale 1ns/10ps

module rv_pc_gen #(
    parameter int              XLEN         = rv_fetch_pkg::XLEN,
    parameter logic [XLEN-1:0] RESET_VECTOR = 'h0000_1000
) (
    input  logic                      clk,
    input  logic                      reset,
    input  rv_fetch_pkg::pc_sel_t     pc_sel,
    input  logic [XLEN-1:0]           next_tgt,
    input  logic                      ras_valid,
    input  logic [XLEN-1:0]           ras_tgt,
    input  rv_fetch_pkg::btb_lookup_t btb,
    output logic [XLEN-1:0]           pc,
    output rv_fetch_pkg::if_id_pred_t if_id,
    // Wishbone classic fetch master
    output logic                      wb_cyc,
    output logic                      wb_stb,
    output logic                      wb_we,
    output logic [3:0]                wb_sel,
    output logic [XLEN-1:0]           wb_adr,
    input  logic                      wb_ack,
    input  logic [31:0]               wb_dat_i,
    output logic [31:0]               instr,
    output logic                      instr_valid
);

    logic fetch_req;
    logic fetch_done;

    // The request goes up one cycle after reset and never drops again
    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_req <= 1'b0;
        end else begin
            fetch_req <= 1'b1;
        end
    end

    // A fetch completes on the edge where the slave acks an active strobe
    assign fetch_done = wb_cyc && wb_stb && wb_ack;

    // PC moves only on the ack edge, so the address holds through wait states
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_VECTOR;
        end else if (fetch_done) begin
            if (pc_sel == rv_fetch_pkg::PC_SEL_SEQ) begin
                pc <= pc + XLEN'(4);
            end else begin
                pc <= next_tgt;
            end
        end
    end

    // IF to ID buffer, reloaded with each instruction that leaves IF
    always_ff @(posedge clk) begin
        if (reset) begin
            if_id <= '0;
        end else if (fetch_done) begin
            if_id.ras_valid     <= ras_valid;
            if_id.btb_hit       <= btb.hit;
            if_id.btb_is_return <= btb.is_return;
            if_id.ras_tgt       <= ras_tgt;
        end
    end

    assign wb_cyc = fetch_req;
    assign wb_stb = fetch_req;
    // Read only port, full word every time
    assign wb_we  = 1'b0;
    assign wb_sel = 4'hf;
    assign wb_adr = {pc[XLEN-1:2], 2'b00};

    // Instruction word is valid only in the ack cycle
    assign instr       = wb_dat_i;
    assign instr_valid = fetch_done;

endmodule

// File: hw/rv_pc_sel.sv
`timescale 1ns/10ps

module rv_pc_sel #(
    parameter int XLEN = rv_fetch_pkg::XLEN
) (
    // MEM-stage misprediction redirect
    input  rv_fetch_pkg::redirect_t   mem_redir,
    // EX-stage redirect for jumps that were never predicted
    input  rv_fetch_pkg::ex_sel_t     ex_sel,
    // Decoder selection and static target for the instruction in ID
    input  rv_fetch_pkg::id_info_t    id_info,
    // Live top of the return address stack
    input  logic                      ras_valid,
    input  logic [XLEN-1:0]           ras_tgt,
    // BTB result for the address being fetched
    input  rv_fetch_pkg::btb_lookup_t btb,
    // IF prediction state that travelled along with the instruction now in ID
    input  rv_fetch_pkg::if_id_pred_t if_id,
    output rv_fetch_pkg::pc_sel_t     pc_sel,
    output logic [XLEN-1:0]           next_tgt,
    output logic                      btb_pred_taken,
    output logic                      ras_pred_taken
);

    logic                  ras_early;
    logic                  ras_late;
    logic                  ras_pred_valid;
    logic                  btb_pred_valid;
    logic                  id_predicted;
    rv_fetch_pkg::pc_sel_t sel_pred;
    logic [XLEN-1:0]       pred_tgt;

    assign id_predicted = (id_info.sel == rv_fetch_pkg::PC_SEL_PREDICTED);

    // Early RAS case: the BTB already knows this fetch address is a return
    assign ras_early = btb.hit && btb.is_return;

    // Late RAS case: ID decoded a JALR that IF did not catch as a return
    // The check uses the buffered BTB bits, which belong to the same instruction
    assign ras_late = id_info.is_jalr && !(if_id.btb_hit && if_id.btb_is_return);

    // Late predictions use the buffered stack state so that a pop between
    // IF and ID cannot make the prediction disagree with what ID saw
    assign ras_pred_valid = (ras_early && ras_valid) || (ras_late && if_id.ras_valid);

    // A BTB entry only predicts a jump when its taken bit is set
    assign btb_pred_valid = btb.hit && btb.taken;

    // First level: ID prediction beats RAS, which beats BTB, which beats static
    always_comb begin
        if (id_predicted) begin
            sel_pred = rv_fetch_pkg::PC_SEL_PREDICTED;
            pred_tgt = id_info.pred_tgt;
        end else if (ras_pred_valid) begin
            sel_pred = rv_fetch_pkg::PC_SEL_PREDICTED;
            // A late prediction must use the target buffered with its JALR,
            // even if IF holds an early prediction for some other address
            pred_tgt = ras_late ? if_id.ras_tgt : ras_tgt;
        end else if (btb_pred_valid) begin
            sel_pred = rv_fetch_pkg::PC_SEL_PREDICTED;
            pred_tgt = btb.tgt;
        end else begin
            // Static fallback, usually SEQ
            sel_pred = id_info.sel;
            pred_tgt = id_info.pred_tgt;
        end
    end

    // Second level: resolved redirects from later stages override any guess
    always_comb begin
        if (mem_redir.valid) begin
            pc_sel   = rv_fetch_pkg::PC_SEL_REDIRECT;
            next_tgt = mem_redir.tgt;
        end else if (ex_sel.sel == rv_fetch_pkg::PC_SEL_REDIRECT) begin
            pc_sel   = rv_fetch_pkg::PC_SEL_REDIRECT;
            next_tgt = ex_sel.tgt;
        end else begin
            pc_sel   = sel_pred;
            next_tgt = pred_tgt;
        end
    end

    // Tells the hazard logic what kind of prediction steered this fetch
    // Early RAS counts as a BTB prediction since no flush is needed,
    // returns are always taken even while the BTB taken bit is still clear
    assign btb_pred_taken = !id_predicted && (btb_pred_valid || ras_early);

    // A late RAS prediction arrives after the wrong-path fetch, so ID gets flushed
    assign ras_pred_taken = !id_predicted && ras_late;

endmodule

// File: hw/rv_ras.sv
`timescale 1ns/10ps

module rv_ras #(
    parameter int XLEN      = rv_fetch_pkg::XLEN,
    parameter int RAS_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  rv_fetch_pkg::ras_op_t op,
    output logic                  ras_valid,
    output logic [XLEN-1:0]       ras_tgt
);

    localparam int PTR_W = (RAS_DEPTH > 1) ? $clog2(RAS_DEPTH) : 1;
    localparam int CNT_W = $clog2(RAS_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST = PTR_W'(RAS_DEPTH - 1);

    logic [XLEN-1:0]  stack [RAS_DEPTH];
    // Points at the current top entry
    logic [PTR_W-1:0] top;
    logic [CNT_W-1:0] count;
    logic [PTR_W-1:0] top_inc;
    logic [PTR_W-1:0] top_dec;

    // Circular neighbours of the top pointer, the depth need not be a power of two
    assign top_inc = (top == LAST) ? '0 : top + 1'b1;
    assign top_dec = (top == '0) ? LAST : top - 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            top   <= '0;
            count <= '0;
        end else if (op.push && op.pop) begin
            // Replacing the top of an empty stack leaves one entry behind
            if (count == '0) begin
                count <= CNT_W'(1);
            end
        end else if (op.push) begin
            top <= top_inc;
            // When full the write lands on the oldest slot and the count saturates
            if (count != CNT_W'(RAS_DEPTH)) begin
                count <= count + 1'b1;
            end
        end else if (op.pop && (count != '0)) begin
            top   <= top_dec;
            count <= count - 1'b1;
        end
    end

    // Return addresses themselves
    always_ff @(posedge clk) begin
        if (op.push && op.pop) begin
            stack[top] <= op.push_addr;
        end else if (op.push) begin
            stack[top_inc] <= op.push_addr;
        end
    end

    assign ras_valid = (count != '0);
    assign ras_tgt   = stack[top];

endmodule

// File: hw/rv_btb.sv
`timescale 1ns/10ps

module rv_btb #(
    parameter int XLEN        = rv_fetch_pkg::XLEN,
    parameter int BTB_ENTRIES = 16
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [XLEN-1:0]           pc,
    input  rv_fetch_pkg::btb_update_t upd,
    output rv_fetch_pkg::btb_lookup_t lookup
);

    // Index comes from the word address bits just above the byte offset
    localparam int IDX_W = (BTB_ENTRIES > 1) ? $clog2(BTB_ENTRIES) : 1;
    // Everything above the index is kept as the tag
    localparam int TAG_W = XLEN - IDX_W - 2;

    // One BTB entry without its valid bit
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  tgt;
        logic             taken;
        logic             is_return;
    } btb_entry_t;

    logic [BTB_ENTRIES-1:0] entry_valid;
    btb_entry_t             entries [BTB_ENTRIES];

    logic [IDX_W-1:0] rd_idx;
    logic [TAG_W-1:0] rd_tag;
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] wr_tag;
    btb_entry_t       rd_entry;

    assign rd_idx = pc[IDX_W+1:2];
    assign rd_tag = pc[XLEN-1:IDX_W+2];
    assign wr_idx = upd.pc[IDX_W+1:2];
    assign wr_tag = upd.pc[XLEN-1:IDX_W+2];

    // Valid bits are the only state that must come up clean
    always_ff @(posedge clk) begin
        if (reset) begin
            entry_valid <= '0;
        end else if (upd.valid) begin
            entry_valid[wr_idx] <= 1'b1;
        end
    end

    // Entry payload, a later update to the same index simply replaces it
    always_ff @(posedge clk) begin
        if (upd.valid) begin
            entries[wr_idx].tag       <= wr_tag;
            entries[wr_idx].tgt       <= upd.tgt;
            entries[wr_idx].taken     <= upd.taken;
            entries[wr_idx].is_return <= upd.is_return;
        end
    end

    assign rd_entry = entries[rd_idx];

    // Combinational lookup on the current PC
    // Taken and is_return are qualified by the hit so a stale entry never leaks
    always_comb begin
        lookup.hit       = entry_valid[rd_idx] && (rd_entry.tag == rd_tag);
        lookup.taken     = lookup.hit && rd_entry.taken;
        lookup.is_return = lookup.hit && rd_entry.is_return;
        lookup.tgt       = rd_entry.tgt;
    end

endmodule

// File: hw/rv_fetch_pkg.sv
package rv_fetch_pkg;

    // Default register width, modules take it as their own XLEN parameter
    parameter int XLEN = 32;

    // Source of the next PC as seen by the PC register
    typedef enum logic [1:0] {
        PC_SEL_SEQ       = 2'b00,
        PC_SEL_PREDICTED = 2'b01,
        PC_SEL_REDIRECT  = 2'b10
    } pc_sel_t;

    // MEM-stage redirect, the highest priority source
    typedef struct packed {
        logic        valid;
        logic [31:0] tgt;
    } redirect_t;

    // EX-stage selection, only the REDIRECT code overrides anything
    typedef struct packed {
        pc_sel_t     sel;
        logic [31:0] tgt;
    } ex_sel_t;

    // Decoder facts and its static prediction for the instruction in ID
    typedef struct packed {
        pc_sel_t     sel;
        logic [31:0] pred_tgt;
        logic        is_jalr;
    } id_info_t;

    // BTB read result for the current fetch address
    typedef struct packed {
        logic        hit;
        logic        taken;
        logic        is_return;
        logic [31:0] tgt;
    } btb_lookup_t;

    // BTB training write, normally driven from EX once a branch resolves
    typedef struct packed {
        logic        valid;
        logic        taken;
        logic        is_return;
        logic [31:0] pc;
        logic [31:0] tgt;
    } btb_update_t;

    // Return address stack command
    typedef struct packed {
        logic        push;
        logic        pop;
        logic [31:0] push_addr;
    } ras_op_t;

    // Prediction state captured in IF and handed to ID with the instruction
    typedef struct packed {
        logic        ras_valid;
        logic        btb_hit;
        logic        btb_is_return;
        logic [31:0] ras_tgt;
    } if_id_pred_t;

endpackage
